//--- include/dec_defines.svh
`ifndef DEC_DEFINES_SVH
`define DEC_DEFINES_SVH

// data and pc width
`define XLEN 32

// -------------------------------------------------------------------------
// rv32i major opcodes
// -------------------------------------------------------------------------
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// immediate formats, decoder to immediate generator
`define SX_U 3'd0
`define SX_I 3'd1
`define SX_S 3'd2
`define SX_B 3'd3
`define SX_J 3'd4

// which sources an instruction reads
`define HZRD_OTHER   2'd0
`define HZRD_RS1     2'd1
`define HZRD_RS1_RS2 2'd2
// load: reads rs1, result only after memory
`define HZRD_LOAD    2'd3

// -------------------------------------------------------------------------
// alu operations
// -------------------------------------------------------------------------
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_OR   4'd7
`define ALU_AND  4'd8
`define ALU_SRA  4'd9

// branch conditions, same as funct3
`define CND_EQ   3'b000
`define CND_NE   3'b001
// unused funct3, marks a non-branch
`define CND_NONE 3'b010
`define CND_LT   3'b100
`define CND_GE   3'b101
`define CND_LTU  3'b110
`define CND_GEU  3'b111

// access sizes, same as funct3
`define MEM_B  3'b000
`define MEM_H  3'b001
`define MEM_W  3'b010
`define MEM_BU 3'b100
`define MEM_HU 3'b101

// operand and result select bits
`define MUX_NONE    6'b000000
`define MUX_A_PC    6'b000001
`define MUX_B_IMM   6'b000010
`define MUX_RES_ALU 6'b000100
`define MUX_RES_MEM 6'b001000
`define MUX_RES_PC4 6'b010000
`define MUX_RES_IMM 6'b100000

`endif

//--- verilog/dec_pkg.sv
package dec_pkg;

	// register-register layout, also the common opcode view
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// immediate, loads, jalr
	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// stores
	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	// branches, offset bits scattered
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	// lui, auipc
	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// jal
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_word_t;

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module reg_file (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [4:0]       rs1,
	input  logic [4:0]       rs2,
	input  logic [4:0]       rd,
	input  logic [`XLEN-1:0] wd,
	input  logic             we,
	output logic [`XLEN-1:0] src1,
	output logic [`XLEN-1:0] src2
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:31];

	// write port, x0 writes dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wd;
		end
	end

	// read ports
	// same-cycle writeback forwarded ahead of the array
	assign src1 = (rs1 == 5'd0) ? '0 :
		(we && rd == rs1) ? wd : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 :
		(we && rd == rs2) ? wd : regs[rs2];

endmodule

//--- verilog/inst_ctrl.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module inst_ctrl (
	input  dec_pkg::inst_word_t inst,
	output logic [2:0]          wb_sx_op,
	output logic [5:0]          mux_bus,
	output logic [3:0]          alu_op,
	output logic [2:0]          alu_cnd,
	output logic                we,
	output logic                mem_val,
	output logic                mem_store,
	output logic [2:0]          mem_size,
	output logic [2:0]          sx_op,
	output logic [1:0]          haz_cmd
);

	import dec_pkg::*;

	// opcode, funct3, funct7 view
	r_fmt_t f;

	assign f = inst.r;

	// funct3 to alu op
	// alt is funct7 bit 5, sub only for register form
	function automatic logic [3:0] alu_sel(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		logic [3:0] op;
		case (f3)
			3'b000: op = (alt && is_reg) ? `ALU_SUB : `ALU_ADD;
			3'b001: op = `ALU_SLL;
			3'b010: op = `ALU_SLT;
			3'b011: op = `ALU_SLTU;
			3'b100: op = `ALU_XOR;
			3'b101: op = alt ? `ALU_SRA : `ALU_SRL;
			3'b110: op = `ALU_OR;
			default: op = `ALU_AND;
		endcase
		return op;
	endfunction

	// -------------------------------------------------------------------------
	// main decode
	// -------------------------------------------------------------------------
	always_comb begin
		// defaults give a no-op
		wb_sx_op  = `MEM_W;
		mux_bus   = `MUX_NONE;
		alu_op    = `ALU_ADD;
		alu_cnd   = `CND_NONE;
		we        = 1'b0;
		mem_val   = 1'b0;
		mem_store = 1'b0;
		mem_size  = `MEM_W;
		sx_op     = `SX_I;
		haz_cmd   = `HZRD_OTHER;
		case (f.opcode)
			`OP_LUI: begin
				we      = 1'b1;
				sx_op   = `SX_U;
				mux_bus = `MUX_B_IMM | `MUX_RES_IMM;
			end
			`OP_AUIPC: begin
				we      = 1'b1;
				sx_op   = `SX_U;
				mux_bus = `MUX_A_PC | `MUX_B_IMM | `MUX_RES_ALU;
			end
			`OP_JAL: begin
				// alu forms the target, rd gets pc+4
				we      = 1'b1;
				sx_op   = `SX_J;
				mux_bus = `MUX_A_PC | `MUX_B_IMM | `MUX_RES_PC4;
			end
			`OP_JALR: begin
				we      = 1'b1;
				sx_op   = `SX_I;
				mux_bus = `MUX_B_IMM | `MUX_RES_PC4;
				haz_cmd = `HZRD_RS1;
			end
			`OP_BRANCH: begin
				// target on the alu, compare on src1/src2
				sx_op   = `SX_B;
				alu_cnd = f.funct3;
				mux_bus = `MUX_A_PC | `MUX_B_IMM;
				haz_cmd = `HZRD_RS1_RS2;
			end
			`OP_LOAD: begin
				we       = 1'b1;
				mem_val  = 1'b1;
				mem_size = f.funct3;
				wb_sx_op = f.funct3;
				sx_op    = `SX_I;
				mux_bus  = `MUX_B_IMM | `MUX_RES_MEM;
				haz_cmd  = `HZRD_LOAD;
			end
			`OP_STORE: begin
				mem_val   = 1'b1;
				mem_store = 1'b1;
				mem_size  = f.funct3;
				sx_op     = `SX_S;
				mux_bus   = `MUX_B_IMM;
				haz_cmd   = `HZRD_RS1_RS2;
			end
			`OP_IMM: begin
				we      = 1'b1;
				sx_op   = `SX_I;
				alu_op  = alu_sel(f.funct3, f.funct7[5], 1'b0);
				mux_bus = `MUX_B_IMM | `MUX_RES_ALU;
				haz_cmd = `HZRD_RS1;
			end
			`OP_REG: begin
				we      = 1'b1;
				alu_op  = alu_sel(f.funct3, f.funct7[5], 1'b1);
				mux_bus = `MUX_RES_ALU;
				haz_cmd = `HZRD_RS1_RS2;
			end
			default: begin
				// unknown opcode stays a no-op
			end
		endcase
	end

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module hazard_unit (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       inst_ack,
	input  logic [1:0] haz_cmd_now,
	input  logic [4:0] rs1_now,
	input  logic [4:0] rs2_now,
	input  logic [4:0] rd_q,
	input  logic [1:0] haz_cmd_q,
	input  logic       valid,
	output logic       bubble
);

	logic started;
	logic uses_rs1;
	logic uses_rs2;
	logic load_use;

	// no stall before the first fetch after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else begin
			started <= 1'b1;
		end
	end

	// a load reads rs1 as well
	assign uses_rs1 = (haz_cmd_now != `HZRD_OTHER);
	assign uses_rs2 = (haz_cmd_now == `HZRD_RS1_RS2);

	// load ahead whose rd feeds decode
	assign load_use = valid && (haz_cmd_q == `HZRD_LOAD) && (rd_q != 5'd0) &&
		((uses_rs1 && rd_q == rs1_now) || (uses_rs2 && rd_q == rs2_now));

	// fetch miss or load-use
	assign bubble = started && (!inst_ack || load_use);

endmodule

//--- verilog/dec_stage.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module dec_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                enb,
	input  logic                kill,
	input  logic                bubble,
	input  dec_pkg::inst_word_t inst,
	input  logic [`XLEN-1:0]    pc,
	input  logic [`XLEN-1:0]    pc_4,
	input  logic                wb_we,
	input  logic [4:0]          wb_rd,
	input  logic [`XLEN-1:0]    wb_data,
	output logic [1:0]          haz_cmd_now,
	output logic [4:0]          rs1_now,
	output logic [4:0]          rs2_now,
	output logic [2:0]          wb_sx_op,
	output logic [5:0]          mux_bus,
	output logic                we,
	output logic [3:0]          alu_op,
	output logic [2:0]          alu_cnd,
	output logic                mem_val,
	output logic                mem_store,
	output logic [2:0]          mem_size,
	output logic [`XLEN-1:0]    src1,
	output logic [`XLEN-1:0]    src2,
	output logic [`XLEN-1:0]    imm,
	output logic [`XLEN-1:0]    pc_q,
	output logic [`XLEN-1:0]    pc_4_q,
	output logic [4:0]          rs1_q,
	output logic [4:0]          rs2_q,
	output logic [4:0]          rd_q,
	output logic [1:0]          haz_cmd_q,
	output logic                valid
);

	import dec_pkg::*;

	// format views of the fetched word
	i_fmt_t i_f;
	s_fmt_t s_f;
	b_fmt_t b_f;
	u_fmt_t u_f;
	j_fmt_t j_f;

	// decoder outputs
	logic [2:0]       wb_sx_op_c;
	logic [5:0]       mux_bus_c;
	logic [3:0]       alu_op_c;
	logic [2:0]       alu_cnd_c;
	logic             we_c;
	logic             mem_val_c;
	logic             mem_store_c;
	logic [2:0]       mem_size_c;
	logic [2:0]       sx_op_c;
	logic [`XLEN-1:0] src1_c;
	logic [`XLEN-1:0] src2_c;
	logic [`XLEN-1:0] imm_c;

	assign i_f = inst.i;
	assign s_f = inst.s;
	assign b_f = inst.b;
	assign u_f = inst.u;
	assign j_f = inst.j;

	// source fields sit at the same bits in every format
	assign rs1_now = i_f.rs1;
	assign rs2_now = s_f.rs2;

	reg_file i_reg_file (
		.clk  (clk),
		.rst_n(rst_n),
		.rs1  (rs1_now),
		.rs2  (rs2_now),
		.rd   (wb_rd),
		.wd   (wb_data),
		.we   (wb_we),
		.src1 (src1_c),
		.src2 (src2_c)
	);

	inst_ctrl i_inst_ctrl (
		.inst     (inst),
		.wb_sx_op (wb_sx_op_c),
		.mux_bus  (mux_bus_c),
		.alu_op   (alu_op_c),
		.alu_cnd  (alu_cnd_c),
		.we       (we_c),
		.mem_val  (mem_val_c),
		.mem_store(mem_store_c),
		.mem_size (mem_size_c),
		.sx_op    (sx_op_c),
		.haz_cmd  (haz_cmd_now)
	);

	// -------------------------------------------------------------------------
	// immediate generator
	// -------------------------------------------------------------------------
	always_comb begin
		case (sx_op_c)
			`SX_U: imm_c = {u_f.imm_31_12, 12'b0};
			`SX_I: imm_c = {{20{i_f.imm_11_0[11]}}, i_f.imm_11_0};
			`SX_S: imm_c = {{20{s_f.imm_11_5[6]}}, s_f.imm_11_5, s_f.imm_4_0};
			// halfword offsets, bit 0 always zero
			`SX_B: imm_c = {{19{b_f.imm_12}}, b_f.imm_12, b_f.imm_11,
				b_f.imm_10_5, b_f.imm_4_1, 1'b0};
			`SX_J: imm_c = {{11{j_f.imm_20}}, j_f.imm_20, j_f.imm_19_12,
				j_f.imm_11, j_f.imm_10_1, 1'b0};
			default: imm_c = '0;
		endcase
	end

	// -------------------------------------------------------------------------
	// execute-bound register
	// -------------------------------------------------------------------------
	// control part, kill beats enb
	always_ff @(posedge clk) begin
		if (!rst_n || kill || (enb && bubble)) begin
			valid     <= 1'b0;
			we        <= 1'b0;
			mem_val   <= 1'b0;
			haz_cmd_q <= `HZRD_OTHER;
		end else if (enb) begin
			valid     <= 1'b1;
			we        <= we_c;
			mem_val   <= mem_val_c;
			haz_cmd_q <= haz_cmd_now;
		end
	end

	// payload, only meaningful with valid
	always_ff @(posedge clk) begin
		if (enb) begin
			wb_sx_op  <= wb_sx_op_c;
			mux_bus   <= mux_bus_c;
			alu_op    <= alu_op_c;
			alu_cnd   <= alu_cnd_c;
			mem_store <= mem_store_c;
			mem_size  <= mem_size_c;
			src1      <= src1_c;
			src2      <= src2_c;
			imm       <= imm_c;
			pc_q      <= pc;
			pc_4_q    <= pc_4;
			rs1_q     <= rs1_now;
			rs2_q     <= rs2_now;
			rd_q      <= u_f.rd;
		end
	end

endmodule

//--- verilog/dec_top.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module dec_top (
	input  logic                clk,
	input  logic                rst_n,
	input  dec_pkg::inst_word_t inst,
	input  logic                inst_ack,
	input  logic [`XLEN-1:0]    pc,
	input  logic [`XLEN-1:0]    pc_4,
	input  logic                wb_we,
	input  logic [4:0]          wb_rd,
	input  logic [`XLEN-1:0]    wb_data,
	input  logic                enb,
	input  logic                kill,
	output logic [2:0]          wb_sx_op,
	output logic [5:0]          mux_bus,
	output logic                we,
	output logic [3:0]          alu_op,
	output logic [2:0]          alu_cnd,
	output logic                mem_val,
	output logic                mem_store,
	output logic [2:0]          mem_size,
	output logic [`XLEN-1:0]    src1,
	output logic [`XLEN-1:0]    src2,
	output logic [`XLEN-1:0]    imm,
	output logic [`XLEN-1:0]    pc_q,
	output logic [`XLEN-1:0]    pc_4_q,
	output logic [4:0]          rs1_q,
	output logic [4:0]          rs2_q,
	output logic [4:0]          rd_q,
	output logic [1:0]          haz_cmd_q,
	output logic                valid,
	output logic                stall
);

	// decode to hazard, current instruction
	logic [1:0] haz_cmd_now;
	logic [4:0] rs1_now;
	logic [4:0] rs2_now;

	// stall doubles as the bubble into decode
	dec_stage i_dec_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.enb        (enb),
		.kill       (kill),
		.bubble     (stall),
		.inst       (inst),
		.pc         (pc),
		.pc_4       (pc_4),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.haz_cmd_now(haz_cmd_now),
		.rs1_now    (rs1_now),
		.rs2_now    (rs2_now),
		.wb_sx_op   (wb_sx_op),
		.mux_bus    (mux_bus),
		.we         (we),
		.alu_op     (alu_op),
		.alu_cnd    (alu_cnd),
		.mem_val    (mem_val),
		.mem_store  (mem_store),
		.mem_size   (mem_size),
		.src1       (src1),
		.src2       (src2),
		.imm        (imm),
		.pc_q       (pc_q),
		.pc_4_q     (pc_4_q),
		.rs1_q      (rs1_q),
		.rs2_q      (rs2_q),
		.rd_q       (rd_q),
		.haz_cmd_q  (haz_cmd_q),
		.valid      (valid)
	);

	hazard_unit i_hazard_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_ack   (inst_ack),
		.haz_cmd_now(haz_cmd_now),
		.rs1_now    (rs1_now),
		.rs2_now    (rs2_now),
		.rd_q       (rd_q),
		.haz_cmd_q  (haz_cmd_q),
		.valid      (valid),
		.bubble     (stall)
	);

endmodule

//--- bench/dec_properties.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module dec_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                enb,
	input logic                kill,
	input logic                inst_ack,
	input dec_pkg::inst_word_t inst,
	input logic                stall,
	input logic                valid,
	input logic                we,
	input logic                mem_val,
	input logic [1:0]          haz_cmd_q,
	input logic [4:0]          rd_q,
	input logic [4:0]          rs1_q,
	input logic [`XLEN-1:0]    src1,
	input logic [`XLEN-1:0]    imm
);

	// failed assertions so far
	int         fail_cnt = 0;
	logic [6:0] op;
	logic       uses_rs1;
	logic       uses_rs2;
	logic       dep_load;

	assign op = inst.r.opcode;

	// sources read by the word in decode, from its rv32i format
	assign uses_rs1 = op inside {`OP_JALR, `OP_BRANCH, `OP_LOAD, `OP_STORE, `OP_IMM, `OP_REG};
	assign uses_rs2 = op inside {`OP_BRANCH, `OP_STORE, `OP_REG};

	// load in execute-bound register feeding decode
	assign dep_load = valid && haz_cmd_q == `HZRD_LOAD && rd_q != 5'd0 &&
		((uses_rs1 && rd_q == inst.r.rs1) ||
		(uses_rs2 && rd_q == inst.r.rs2));

	a_reset_clear: assert property (@(posedge clk) !rst_n |=>
		(!valid && !we && !mem_val && !stall && haz_cmd_q == `HZRD_OTHER))
		else begin fail_cnt++; $error("control not cleared after reset"); end

	a_kill_clear: assert property (@(posedge clk) disable iff (!rst_n)
		kill |=> (!valid && !we && !mem_val && haz_cmd_q == `HZRD_OTHER))
		else begin fail_cnt++; $error("kill did not clear the register"); end

	a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		(enb && stall && !kill) |=> !valid)
		else begin fail_cnt++; $error("bubble did not clear valid"); end

	// back-pressure
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!enb && !kill) |=> ($stable(valid) && $stable(src1) && $stable(imm) && $stable(rd_q)))
		else begin fail_cnt++; $error("outputs moved with enb low"); end

	a_fetch_stall: assert property (@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && !inst_ack) |-> stall)
		else begin fail_cnt++; $error("no stall on missing inst_ack"); end

	a_load_use: assert property (@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && dep_load) |-> stall)
		else begin fail_cnt++; $error("load-use not stalled"); end

	// independent instruction passes
	a_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_ack && !dep_load) |-> !stall)
		else begin fail_cnt++; $error("stall without a hazard"); end

	a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && inst_ack && enb && !kill) |=> (!stall || !inst_ack))
		else begin fail_cnt++; $error("load-use stall longer than one cycle"); end

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(valid && rs1_q == 5'd0) |-> src1 == '0)
		else begin fail_cnt++; $error("x0 read nonzero"); end

endmodule

//--- bench/dec_tb.sv
`timescale 1ns/100ps
`include "dec_defines.svh"

module dec_tb;

	import dec_pkg::*;

	localparam int NUM_INST   = 2000;
	localparam int MAX_CYCLES = 40000;

	// fetch, writeback and pipeline controller stand-ins
	logic             clk, rst_n, inst_ack, wb_we, enb, kill;
	inst_word_t       inst;
	logic [`XLEN-1:0] pc, pc_4, wb_data;
	logic [4:0]       wb_rd;
	// execute-bound register
	logic [2:0]       wb_sx_op, alu_cnd, mem_size;
	logic [5:0]       mux_bus;
	logic [3:0]       alu_op;
	logic             we, mem_val, mem_store, valid, stall;
	logic [`XLEN-1:0] src1, src2, imm, pc_q, pc_4_q;
	logic [4:0]       rs1_q, rs2_q, rd_q;
	logic [1:0]       haz_cmd_q;

	// reference model state
	logic [31:0] shadow [0:31];
	logic [31:0] lfsr;
	logic [31:0] exp_inst, exp_src1, exp_src2, exp_pc;
	logic        exp_valid;

	dec_top i_dut (.*);

	bind dec_top dec_properties i_dec_props (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] want);
		abort_run($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
			$time, name, got, want));
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// reference rules from the rv32i encoding
	// ------------------------------------------------------------------------
	function automatic logic writes_rd(input logic [6:0] op);
		return op inside {`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_LOAD, `OP_IMM, `OP_REG};
	endfunction

	function automatic logic [1:0] haz_of(input logic [6:0] op);
		case (op)
			`OP_JALR, `OP_IMM: return `HZRD_RS1;
			`OP_BRANCH, `OP_STORE, `OP_REG: return `HZRD_RS1_RS2;
			`OP_LOAD: return `HZRD_LOAD;
			default: return `HZRD_OTHER;
		endcase
	endfunction

	// operand a from pc, operand b from imm, and where the result comes from
	function automatic logic [5:0] mux_of(input logic [6:0] op);
		logic [5:0] m;
		m = `MUX_NONE;
		if (op inside {`OP_AUIPC, `OP_JAL, `OP_BRANCH}) begin
			m |= `MUX_A_PC;
		end
		if (op inside {`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH, `OP_LOAD,
			`OP_STORE, `OP_IMM}) begin
			m |= `MUX_B_IMM;
		end
		if (op inside {`OP_AUIPC, `OP_IMM, `OP_REG}) begin
			m |= `MUX_RES_ALU;
		end
		if (op == `OP_LOAD) begin
			m |= `MUX_RES_MEM;
		end
		// link address for both jumps
		if (op inside {`OP_JAL, `OP_JALR}) begin
			m |= `MUX_RES_PC4;
		end
		if (op == `OP_LUI) begin
			m |= `MUX_RES_IMM;
		end
		return m;
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] w);
		case (w[6:0])
			`OP_LUI, `OP_AUIPC: return {w[31:12], 12'h000};
			`OP_JAL: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			`OP_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			`OP_STORE: return {{21{w[31]}}, w[30:25], w[11:7]};
			default: return {{21{w[31]}}, w[30:20]};
		endcase
	endfunction

	// bit 30 picks sub (register form only) and arithmetic shift
	function automatic logic [3:0] alu_of(input logic [31:0] w);
		logic reg_form;
		reg_form = (w[6:0] == `OP_REG);
		if (!reg_form && w[6:0] != `OP_IMM) begin
			return `ALU_ADD;
		end
		case (w[14:12])
			3'b000: return (reg_form && w[30]) ? `ALU_SUB : `ALU_ADD;
			3'b001: return `ALU_SLL;
			3'b010: return `ALU_SLT;
			3'b011: return `ALU_SLTU;
			3'b100: return `ALU_XOR;
			3'b101: return w[30] ? `ALU_SRA : `ALU_SRL;
			3'b110: return `ALU_OR;
			default: return `ALU_AND;
		endcase
	endfunction

	// shadow read, same-cycle writeback wins
	function automatic logic [31:0] read_reg(input logic [4:0] r);
		if (r == 5'd0) begin
			return '0;
		end
		if (wb_we && wb_rd == r) begin
			return wb_data;
		end
		return shadow[r];
	endfunction

	function automatic logic [31:0] new_inst();
		logic [31:0] w;
		logic [6:0]  op;
		logic [2:0]  f3;
		w = rand_bits(32);
		case (rand_bits(4))
			0, 1, 2: op = `OP_LOAD;
			3, 4: op = `OP_STORE;
			5: op = `OP_BRANCH;
			6, 7, 14: op = `OP_IMM;
			8, 9: op = `OP_REG;
			10: op = `OP_LUI;
			11: op = `OP_AUIPC;
			12: op = `OP_JAL;
			13: op = `OP_JALR;
			default: op = 7'b1111111;
		endcase
		w[6:0] = op;
		// x0..x7 only, so loads and their users collide often
		if (op != `OP_STORE && op != `OP_BRANCH) begin
			w[11:7] = 5'(rand_bits(3));
		end
		if (!(op inside {`OP_LUI, `OP_AUIPC, `OP_JAL})) begin
			w[19:15] = 5'(rand_bits(3));
		end
		if (op inside {`OP_STORE, `OP_BRANCH, `OP_REG}) begin
			w[24:20] = 5'(rand_bits(3));
		end
		f3 = 3'(rand_bits(3));
		if (op == `OP_LOAD) begin
			w[14:12] = (f3 inside {3'b011, 3'b110, 3'b111}) ? `MEM_W : f3;
		end
		if (op == `OP_STORE) begin
			w[14:12] = (f3[1:0] == 2'b11) ? `MEM_B : {1'b0, f3[1:0]};
		end
		return w;
	endfunction

	// outputs against the expected register contents
	task automatic check_outputs();
		logic [6:0] op;
		logic       e_we, e_mem;
		logic [1:0] e_haz;
		op    = exp_inst[6:0];
		e_we  = exp_valid && writes_rd(op);
		e_mem = exp_valid && (op == `OP_LOAD || op == `OP_STORE);
		e_haz = exp_valid ? haz_of(op) : `HZRD_OTHER;
		assert (valid === exp_valid) else value_error("valid", 32'(valid), 32'(exp_valid));
		assert (we === e_we) else value_error("we", 32'(we), 32'(e_we));
		assert (mem_val === e_mem) else value_error("mem_val", 32'(mem_val), 32'(e_mem));
		assert (haz_cmd_q === e_haz) else value_error("haz_cmd", 32'(haz_cmd_q), 32'(e_haz));
		if (exp_valid) begin
			assert (src1 === exp_src1) else value_error("src1", src1, exp_src1);
			assert (src2 === exp_src2) else value_error("src2", src2, exp_src2);
			assert (pc_q === exp_pc) else value_error("pc_q", pc_q, exp_pc);
			assert (pc_4_q === exp_pc + 32'd4) else value_error("pc_4_q", pc_4_q, exp_pc + 32'd4);
			assert (rd_q === exp_inst[11:7]) else value_error("rd", 32'(rd_q), 32'(exp_inst[11:7]));
			assert (rs1_q === exp_inst[19:15])
				else value_error("rs1", 32'(rs1_q), 32'(exp_inst[19:15]));
			assert (rs2_q === exp_inst[24:20])
				else value_error("rs2", 32'(rs2_q), 32'(exp_inst[24:20]));
			assert (mem_store === (op == `OP_STORE))
				else value_error("mem_store", 32'(mem_store), 32'(op == `OP_STORE));
			assert (alu_op === alu_of(exp_inst))
				else value_error("alu_op", 32'(alu_op), 32'(alu_of(exp_inst)));
			assert (mux_bus === mux_of(op))
				else value_error("mux_bus", 32'(mux_bus), 32'(mux_of(op)));
			if (op != 7'b1111111) begin
				assert (imm === imm_of(exp_inst)) else value_error("imm", imm, imm_of(exp_inst));
			end
			if (e_mem) begin
				assert (mem_size === exp_inst[14:12])
					else value_error("mem_size", 32'(mem_size), 32'(exp_inst[14:12]));
			end
			if (op == `OP_LOAD) begin
				assert (wb_sx_op === exp_inst[14:12])
					else value_error("wb_sx_op", 32'(wb_sx_op), 32'(exp_inst[14:12]));
			end
			if (op == `OP_BRANCH) begin
				assert (alu_cnd === exp_inst[14:12])
					else value_error("alu_cnd", 32'(alu_cnd), 32'(exp_inst[14:12]));
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus and model
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] cur, cur_pc, rd1, rd2;
		logic [4:0]  ld_rd;
		logic [1:0]  hz;
		logic        lu, stall_exp, fetch_new;
		int          accepted, cycles;
		rst_n    = 1'b0;
		inst     = '0;
		inst_ack = 1'b0;
		pc       = '0;
		pc_4     = '0;
		wb_we    = 1'b0;
		wb_rd    = '0;
		wb_data  = '0;
		enb      = 1'b0;
		kill     = 1'b0;
		lfsr     = 32'hb041_a2d9;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0;
		end
		exp_valid = 1'b0;
		exp_inst  = '0;
		exp_src1  = '0;
		exp_src2  = '0;
		exp_pc    = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!valid && !we && !mem_val && !stall && haz_cmd_q == `HZRD_OTHER)
			else abort_run("control outputs were not cleared by reset");
		cur      = new_inst();
		cur_pc   = 32'h0000_1000;
		accepted = 0;
		cycles   = 0;
		while (accepted < NUM_INST) begin
			assert (cycles < MAX_CYCLES)
				else abort_run("timeout while waiting for the decode stage to accept instructions");
			cycles++;
			@(posedge clk);
			inst     <= cur;
			pc       <= cur_pc;
			pc_4     <= cur_pc + 32'd4;
			inst_ack <= (rand_bits(3) != 0);
			enb      <= (rand_bits(3) != 0);
			kill     <= (rand_bits(5) == 0);
			wb_we    <= (rand_bits(1) != 0);
			wb_rd    <= 5'(rand_bits(3));
			wb_data  <= rand_bits(32);
			@(negedge clk);
			check_outputs();
			assert (i_dut.i_dec_props.fail_cnt == 0)
				else abort_run("a bound property assertion failed");
			// load ahead feeding the instruction in decode
			hz    = haz_of(cur[6:0]);
			ld_rd = exp_inst[11:7];
			lu    = exp_valid && exp_inst[6:0] == `OP_LOAD && ld_rd != 5'd0 &&
				((hz != `HZRD_OTHER && ld_rd == cur[19:15]) ||
				(hz == `HZRD_RS1_RS2 && ld_rd == cur[24:20]));
			stall_exp = !inst_ack || lu;
			assert (stall === stall_exp) else value_error("stall", 32'(stall), 32'(stall_exp));
			rd1       = read_reg(cur[19:15]);
			rd2       = read_reg(cur[24:20]);
			fetch_new = kill;
			if (kill || (enb && stall_exp)) begin
				exp_valid = 1'b0;
			end else if (enb) begin
				exp_valid = 1'b1;
				exp_inst  = cur;
				exp_pc    = cur_pc;
				exp_src1  = rd1;
				exp_src2  = rd2;
				fetch_new = 1'b1;
				accepted++;
			end
			if (wb_we && wb_rd != 5'd0) begin
				shadow[wb_rd] = wb_data;
			end
			if (fetch_new) begin
				cur    = new_inst();
				cur_pc = cur_pc + 32'd4;
			end
		end
		if (i_dut.i_dec_props.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("a bound property assertion failed");
		end
	end

endmodule

//--- sim.f
+incdir+include
verilog/dec_pkg.sv
verilog/reg_file.sv
verilog/inst_ctrl.sv
verilog/hazard_unit.sv
verilog/dec_stage.sv
verilog/dec_top.sv
bench/dec_properties.sv
bench/dec_tb.sv

//--- Makefile
TOP := dec_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
